// ==== hdl/muon_pkg.sv ====
package muon_pkg;

    // ************************************************************
    // Data widths
    // ************************************************************
    localparam int SAMPLE_W = 12;                      // ADC word width
    localparam int DIFF_W   = 13;                      // Padded signed difference
    localparam int AREA_W   = 24;                      // Signed area accumulator
    localparam int TIME_W   = 32;                      // Cycle timestamp
    localparam int DROP_W   = 16;                      // Dropped event counter

    // ************************************************************
    // Timing constants
    // ************************************************************
    localparam int BASE_LOG2    = 4;                   // 16 samples per baseline block
    localparam int SKIP_SAMPLES = 20;                  // Start-up strobes ignored
    localparam int COINC_WINDOW = 64;                  // Window length in clocks

    // Derived counter widths
    localparam int SKIP_W = $clog2(SKIP_SAMPLES + 1);  // Skip countdown
    localparam int BSUM_W = SAMPLE_W + BASE_LOG2;      // Block sum, no overflow
    localparam int WIN_W  = $clog2(COINC_WINDOW + 1);  // Window countdown

    // ************************************************************
    // Types
    // ************************************************************
    typedef logic        [SAMPLE_W-1:0] sample_t;      // Raw unsigned ADC sample
    typedef logic signed [DIFF_W-1:0]   diff_t;        // Sample minus baseline

    // One finished pulse
    typedef struct packed {
        diff_t                    peak;                // Largest difference
        logic signed [AREA_W-1:0] area;                // Sum of differences
    } pulse_t;

    // One coincidence record
    typedef struct packed {
        logic [TIME_W-1:0] timestamp;                  // Cycle of first pulse
        pulse_t            pulse_a;                    // Channel A measurement
        pulse_t            pulse_b;                    // Channel B measurement
    } event_t;

endpackage

// ==== hdl/baseline_tracker.sv ====
`timescale 1ns/1ps

module baseline_tracker import muon_pkg::*; (
    input  logic    clk,             // System clock
    input  logic    arst_n,          // Async reset, active low
    input  logic    sample_valid,    // Sample strobe
    input  sample_t sample,          // Raw ADC word
    input  logic    quiet,           // Sample not over threshold
    output sample_t baseline,        // Block-averaged DC level
    output logic    baseline_valid   // Set after first full block
);

    logic [SKIP_W-1:0]    skip_cnt;  // Start-up strobes left
    logic [BASE_LOG2-1:0] blk_cnt;   // Samples taken in this block
    logic [BSUM_W-1:0]    acc;       // Running block sum
    logic [BSUM_W-1:0]    acc_next;  // Sum including current sample
    logic                 skipping;  // Still in start-up period
    logic                 take;      // Sample goes into the block
    logic                 blk_last;  // Sample closes the block

    assign skipping = (skip_cnt != '0);
    // First block takes everything, later blocks only quiet samples
    assign take     = sample_valid && !skipping && (quiet || !baseline_valid);
    assign blk_last = &blk_cnt;                        // Last slot of 2^BASE_LOG2
    assign acc_next = acc + BSUM_W'(sample);

    // ************************************************************
    // Start-up skip
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            skip_cnt <= SKIP_W'(SKIP_SAMPLES);        // Load full skip count
        end else if (sample_valid && skipping) begin
            skip_cnt <= skip_cnt - 1'b1;              // One strobe consumed
        end
    end

    // ************************************************************
    // Block averaging
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            blk_cnt        <= '0;
            acc            <= '0;
            baseline_valid <= 1'b0;
        end else if (take) begin
            if (blk_last) begin
                blk_cnt        <= '0;                 // Start next block
                acc            <= '0;
                baseline_valid <= 1'b1;               // Stays set from here on
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
                acc     <= acc_next;
            end
        end
    end

    // Average is the top bits of the block sum
    always_ff @(posedge clk) begin
        if (take && blk_last) begin
            baseline <= acc_next[BSUM_W-1:BASE_LOG2]; // Divide by block size
        end
    end

endmodule

// ==== hdl/pulse_analyzer.sv ====
`timescale 1ns/1ps

module pulse_analyzer import muon_pkg::*; (
    input  logic    clk,            // System clock
    input  logic    arst_n,         // Async reset, active low
    input  logic    sample_valid,   // Sample strobe
    input  sample_t sample,         // Raw ADC word
    input  diff_t   threshold,      // Pulse threshold above baseline
    output logic    pulse_valid,    // One-cycle finished pulse flag
    output pulse_t  pulse           // Peak and area of finished pulse
);

    sample_t                  baseline;        // Current DC level
    logic                     baseline_valid;  // Baseline usable
    diff_t                    diff;            // Sample minus baseline
    logic                     over;            // Over threshold this sample
    logic                     quiet;           // Inverse of over for the tracker
    logic                     in_pulse;        // Inside a pulse
    diff_t                    peak_run;        // Running maximum
    logic signed [AREA_W-1:0] area_run;        // Running area

    // ************************************************************
    // Baseline
    // ************************************************************
    baseline_tracker base0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .quiet          (quiet),               // Keep pulses out of the average
        .baseline       (baseline),
        .baseline_valid (baseline_valid)
    );

    // Zero-pad both to 13 bits so the result is signed
    assign diff  = diff_t'({1'b0, sample}) - diff_t'({1'b0, baseline});
    assign over  = baseline_valid && (diff > threshold);  // Signed compare
    assign quiet = !over;

    // ************************************************************
    // Pulse state
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pulse    <= 1'b0;
            pulse_valid <= 1'b0;
        end else begin
            pulse_valid <= 1'b0;                       // Default single cycle
            if (sample_valid) begin
                if (over) begin
                    in_pulse <= 1'b1;                  // Start or continue
                end else if (in_pulse) begin
                    in_pulse    <= 1'b0;               // First quiet sample ends it
                    pulse_valid <= 1'b1;
                end
            end
        end
    end

    // ************************************************************
    // Peak and area measurement
    // ************************************************************
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            if (over) begin
                if (!in_pulse) begin
                    peak_run <= diff;                  // First sample of pulse
                    area_run <= AREA_W'(diff);         // Sign extended
                end else begin
                    if (diff > peak_run) begin
                        peak_run <= diff;              // New maximum
                    end
                    area_run <= area_run + AREA_W'(diff);
                end
            end else if (in_pulse) begin
                pulse.peak <= peak_run;                // Latch finished pulse
                pulse.area <= area_run;
            end
        end
    end

endmodule

// ==== hdl/coincidence_builder.sv ====
`timescale 1ns/1ps

module coincidence_builder import muon_pkg::*; (
    input  logic              clk,            // System clock
    input  logic              arst_n,         // Async reset, active low
    input  logic              pulse_valid_a,  // Channel A pulse done
    input  logic              pulse_valid_b,  // Channel B pulse done
    input  pulse_t            pulse_a,        // Channel A measurement
    input  pulse_t            pulse_b,        // Channel B measurement
    input  logic              event_ready,    // Receiver accepts
    output logic              event_valid,    // Event record on offer
    output event_t            event_data,     // Held event record
    output logic [DROP_W-1:0] dropped_count   // Saturating drop count
);

    logic [TIME_W-1:0] ts;         // Free running cycle count
    logic [WIN_W-1:0]  win_cnt;    // Cycles left in window
    logic              win_open;   // A pulse is waiting
    pulse_t            st_pulse;   // Stored first pulse
    logic              st_chan_b;  // Stored pulse came from B
    logic [TIME_W-1:0] st_time;    // Timestamp of stored pulse
    logic              pair_now;   // Both channels this cycle
    logic              pair_win;   // Other channel inside window
    logic              coinc;      // Coincidence forms this cycle
    logic              opening;    // Store pulse and (re)start window
    logic              load;       // Coincidence goes to output
    logic              drop;       // Output busy so discard
    event_t            ev_next;    // Assembled record

    assign win_open = (win_cnt != '0);
    assign pair_now = pulse_valid_a && pulse_valid_b;
    assign pair_win = win_open &&
                      ((pulse_valid_a && st_chan_b) || (pulse_valid_b && !st_chan_b));
    assign coinc    = pair_now || pair_win;
    assign opening  = !coinc && (pulse_valid_a || pulse_valid_b);  // Also same-channel replace
    assign load     = coinc && !event_valid;
    assign drop     = coinc && event_valid;

    // Each channel lands in its own field
    always_comb begin
        ev_next.timestamp = pair_now ? ts : st_time;
        ev_next.pulse_a   = pulse_a;
        ev_next.pulse_b   = pulse_b;
        if (!pair_now) begin
            if (st_chan_b) begin
                ev_next.pulse_b = st_pulse;            // B was first
            end else begin
                ev_next.pulse_a = st_pulse;            // A was first
            end
        end
    end

    // ************************************************************
    // Timestamp and window
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ts        <= '0;
            win_cnt   <= '0;
            st_chan_b <= 1'b0;
        end else begin
            ts <= ts + 1'b1;                           // Wraps freely
            if (coinc) begin
                win_cnt <= '0;                         // Pair consumed
            end else if (opening) begin
                win_cnt   <= WIN_W'(COINC_WINDOW);
                st_chan_b <= pulse_valid_b;
            end else if (win_open) begin
                win_cnt <= win_cnt - 1'b1;             // Expiry discards pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (opening) begin
            st_pulse <= pulse_valid_b ? pulse_b : pulse_a;
            st_time  <= ts;                            // Time of this cycle
        end
    end

    // ************************************************************
    // Output hold and drop counter
    // ************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            event_valid   <= 1'b0;
            dropped_count <= '0;
        end else begin
            if (load) begin
                event_valid <= 1'b1;
            end else if (event_valid && event_ready) begin
                event_valid <= 1'b0;                   // Handshake done
            end
            if (drop && (dropped_count != {DROP_W{1'b1}})) begin
                dropped_count <= dropped_count + 1'b1; // Saturates at max
            end
        end
    end

    // Record stays put while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            event_data <= ev_next;
        end
    end

endmodule

// ==== hdl/muon_coinc_top.sv ====
`timescale 1ns/1ps

module muon_coinc_top import muon_pkg::*; (
    input  logic              clk,            // System clock
    input  logic              arst_n,         // Async reset, active low
    input  logic              sample_valid,   // Shared sample strobe
    input  sample_t           sample_a,       // Channel A ADC word
    input  sample_t           sample_b,       // Channel B ADC word
    input  diff_t             threshold,      // Common pulse threshold
    input  logic              event_ready,    // Receiver accepts
    output logic              event_valid,    // Event on offer
    output event_t            event_data,     // Event record
    output logic [DROP_W-1:0] dropped_count   // Events lost to back-pressure
);

    logic   pulse_valid_a;                    // A pulse done
    logic   pulse_valid_b;                    // B pulse done
    pulse_t pulse_a;                          // A peak and area
    pulse_t pulse_b;                          // B peak and area

    // ************************************************************
    // Channel analyzers
    // ************************************************************
    pulse_analyzer chan_a (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample       (sample_a),
        .threshold    (threshold),
        .pulse_valid  (pulse_valid_a),
        .pulse        (pulse_a)
    );

    pulse_analyzer chan_b (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample       (sample_b),
        .threshold    (threshold),
        .pulse_valid  (pulse_valid_b),
        .pulse        (pulse_b)
    );

    // Pairs the two pulse streams into events
    coincidence_builder coinc0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .pulse_valid_a (pulse_valid_a),
        .pulse_valid_b (pulse_valid_b),
        .pulse_a       (pulse_a),
        .pulse_b       (pulse_b),
        .event_ready   (event_ready),
        .event_valid   (event_valid),
        .event_data    (event_data),
        .dropped_count (dropped_count)
    );

endmodule

// ==== testbench/muon_coinc_chk.sv ====
`timescale 1ns/1ps

module muon_coinc_chk import muon_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input logic              event_valid,
    input logic              event_ready,
    input event_t            event_data,
    input logic [DROP_W-1:0] dropped_count
);

    // ************************************************************
    // Output handshake properties
    // ************************************************************
    // Stalled record must not move
    a_hold_stable : assert property (@(posedge clk) disable iff (!arst_n)
        (event_valid && !event_ready) |=> (event_valid && $stable(event_data)))
        else $error("event record changed or dropped while stalled");

    a_reset_quiet : assert property (@(posedge clk)
        !arst_n |-> !event_valid)                      // Nothing offered in reset
        else $error("event_valid high during reset");

    // Counter only climbs
    a_drop_mono : assert property (@(posedge clk) disable iff (!arst_n)
        dropped_count >= $past(dropped_count))
        else $error("dropped_count decreased");

endmodule

bind muon_coinc_top muon_coinc_chk chk0 (
    .clk           (clk),
    .arst_n        (arst_n),
    .event_valid   (event_valid),
    .event_ready   (event_ready),
    .event_data    (event_data),
    .dropped_count (dropped_count)
);

// ==== testbench/event_monitor.sv ====
`timescale 1ns/1ps

module event_monitor import muon_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input logic              event_valid,
    input logic              event_ready,
    input event_t            event_data,
    input logic [DROP_W-1:0] dropped_count
);

    pulse_t            exp_a_q[$];       // Expected channel A results
    pulse_t            exp_b_q[$];       // Expected channel B results
    int                exp_drops;        // Coincidences that must be dropped
    int                mismatch_count;   // Wrong values
    int                other_count;      // Protocol and timeout failures
    int                ev_idx;           // Accepted event number
    logic [TIME_W-1:0] last_ts;          // Previous timestamp
    logic              seen_reset_exit;  // First active cycle checked

    initial begin
        exp_drops       = 0;
        mismatch_count  = 0;
        other_count     = 0;
        ev_idx          = 0;
        last_ts         = '0;
        seen_reset_exit = 1'b0;
    end

    // Queue one expected coincidence, or count it as a drop
    task automatic add_expected(input pulse_t pa, input pulse_t pb, input bit dropped);
        if (dropped) begin
            exp_drops = exp_drops + 1;
        end else begin
            exp_a_q.push_back(pa);
            exp_b_q.push_back(pb);
        end
    endtask

    task automatic compare_field(input string name, input int expv, input int actv);
        if (expv != actv) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expv, actv);
            mismatch_count = mismatch_count + 1;
        end
    endtask

    function automatic int pending();
        return exp_a_q.size();
    endfunction

    // Closing comparison of the drop counter
    task automatic check_drops();
        compare_field("dropped_count", exp_drops, int'(dropped_count));
    endtask

    // ************************************************************
    // Accepted event checking
    // ************************************************************
    always @(posedge clk) begin
        pulse_t ea;
        pulse_t eb;
        if (arst_n && !seen_reset_exit) begin
            seen_reset_exit <= 1'b1;                   // State right after reset
            compare_field("reset event_valid", 0, int'(event_valid));
            compare_field("reset dropped_count", 0, int'(dropped_count));
        end
        if (arst_n && event_valid && event_ready) begin
            ev_idx = ev_idx + 1;
            if (exp_a_q.size() == 0) begin
                $display("ERROR: event %0d accepted but none was expected", ev_idx);
                other_count = other_count + 1;
            end else begin
                ea = exp_a_q.pop_front();
                eb = exp_b_q.pop_front();
                compare_field($sformatf("event%0d peak_a", ev_idx),
                              int'(ea.peak), int'(event_data.pulse_a.peak));
                compare_field($sformatf("event%0d area_a", ev_idx),
                              int'(ea.area), int'(event_data.pulse_a.area));
                compare_field($sformatf("event%0d peak_b", ev_idx),
                              int'(eb.peak), int'(event_data.pulse_b.peak));
                compare_field($sformatf("event%0d area_b", ev_idx),
                              int'(eb.area), int'(event_data.pulse_b.area));
            end
            if (ev_idx > 1 && event_data.timestamp <= last_ts) begin
                $display("ERROR: event %0d timestamp did not increase", ev_idx);
                other_count = other_count + 1;
            end
            last_ts = event_data.timestamp;
        end
    end

endmodule

// ==== testbench/tb_muon_coinc.sv ====
`timescale 1ns/1ps

module tb_muon_coinc import muon_pkg::*; ();

    localparam int STROBE_GAP = 4;             // Clocks per sample strobe
    localparam int DRAIN_MAX  = 2000;          // Clocks allowed to drain events

    logic              clk;
    logic              arst_n;
    logic              sample_valid;
    sample_t           sample_a;
    sample_t           sample_b;
    diff_t             threshold;
    logic              event_ready;
    logic              event_valid;
    event_t            event_data;
    logic [DROP_W-1:0] dropped_count;
    logic [31:0]       lcg_state;              // Back-pressure generator
    logic              hold_ready;             // Force ready low

    muon_coinc_top dut0 (.*);

    event_monitor mon0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .event_valid   (event_valid),
        .event_ready   (event_ready),
        .event_data    (event_data),
        .dropped_count (dropped_count)
    );

    always #4 clk = ~clk;                      // 8 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Random ready changed on the falling edge
    always @(negedge clk) begin
        lcg_state   <= lcg_next(lcg_state);
        event_ready <= hold_ready ? 1'b0 : lcg_state[16];
    end

    // One strobe then idle clocks up to the strobe spacing
    task automatic send_samples(input int a, input int b, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            sample_valid = 1'b1;
            sample_a     = sample_t'(a);
            sample_b     = sample_t'(b);
            @(negedge clk);
            sample_valid = 1'b0;
            repeat (STROBE_GAP - 2) @(negedge clk);
        end
    endtask

    initial begin
        int     fd;
        int     rc;
        int     a;
        int     b;
        int     c;
        int     d;
        int     e;
        int     waited;
        byte    kind;
        pulse_t pa;
        pulse_t pb;
        reg [8*256-1:0] skip_line;
        clk          = 1'b0;
        arst_n       = 1'b0;
        sample_valid = 1'b0;
        sample_a     = '0;
        sample_b     = '0;
        threshold    = diff_t'(30);
        event_ready  = 1'b0;
        hold_ready   = 1'b0;
        lcg_state    = 32'd51478;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen("testbench/muon_testdata.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stimulus file");
            mon0.other_count = mon0.other_count + 1;
        end else begin
            // ************************************************************
            // Stimulus file loop
            // ************************************************************
            while (!$feof(fd)) begin
                rc = $fscanf(fd, " %c", kind);
                if (rc != 1) break;
                case (kind)
                    "#": rc = $fgets(skip_line, fd);   // Comment line
                    "T": begin
                        rc = $fscanf(fd, "%d", a);
                        @(negedge clk);
                        threshold = diff_t'(a);
                    end
                    "S": begin
                        rc = $fscanf(fd, "%d %d %d", a, b, c);
                        send_samples(a, b, c);
                    end
                    "H": begin
                        rc = $fscanf(fd, "%d", a);
                        @(posedge clk);
                        hold_ready = (a == 0);         // 0 stalls the receiver
                    end
                    "E": begin
                        rc = $fscanf(fd, "%d %d %d %d %d", a, b, c, d, e);
                        pa.peak = diff_t'(a);
                        pa.area = AREA_W'(b);
                        pb.peak = diff_t'(c);
                        pb.area = AREA_W'(d);
                        mon0.add_expected(pa, pb, e != 0);
                    end
                    default: begin
                        $display("ERROR: unknown record type in stimulus file");
                        mon0.other_count = mon0.other_count + 1;
                    end
                endcase
            end
            $fclose(fd);
        end

        hold_ready = 1'b0;
        waited     = 0;
        while (mon0.pending() != 0 && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (mon0.pending() != 0) begin
            $display("ERROR: timed out waiting for %0d expected events", mon0.pending());
            mon0.other_count = mon0.other_count + 1;
        end
        mon0.check_drops();

        $display("Result: %0d mismatches, %0d other errors",
                 mon0.mismatch_count, mon0.other_count);
        if (mon0.mismatch_count == 0 && mon0.other_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/muon_testdata.txt ====
# T thr | S sample_a sample_b repeat | H ready_enable
# E peak_a area_a peak_b area_b dropped  (given before the samples that cause it)
T 30
# Skip period with large pulses then flat first block
S 2000 2000 3
S 100 100 17
S 100 100 16
# Same-sample pulse on both channels
E 100 210 80 170 0
S 150 140 1
S 200 180 1
S 160 150 1
S 100 100 20
# Channel B three strobes after channel A
E 200 200 150 150 0
S 300 100 1
S 100 100 2
S 100 250 1
S 100 100 20
# Single channel then a far offset, no events
S 400 100 1
S 100 100 20
S 400 100 1
S 100 100 25
S 100 400 1
S 100 100 25
# Threshold raised then lowered
T 20
S 110 110 1
S 100 100 20
T 5
E 10 10 10 10 0
S 110 110 1
S 100 100 20
T 30
# Receiver stalled
H 0
E 50 50 60 60 0
S 150 160 1
S 100 100 3
E 70 70 80 80 1
S 170 180 1
S 100 100 3
E 90 90 40 40 1
S 190 140 1
S 100 100 3
H 1
S 100 100 10
# Random back-pressure
E 120 230 90 90 0
S 220 190 1
S 210 100 1
S 100 100 20
E 45 45 300 600 0
S 145 400 1
S 100 400 1
S 100 100 20
E 35 35 35 35 0
S 135 135 1
S 100 100 20

// ==== filelist.f ====
hdl/muon_pkg.sv
hdl/baseline_tracker.sv
hdl/pulse_analyzer.sv
hdl/coincidence_builder.sv
hdl/muon_coinc_top.sv
testbench/muon_coinc_chk.sv
testbench/event_monitor.sv
testbench/tb_muon_coinc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_muon_coinc
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass line in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
